/* verilog/cci_pkg.sv */
// --------------------------------------
// Host link format
// Line and header widths, CSR indices and write opcodes
// --------------------------------------

package cci_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int LINE_W   = 256;            // One cache line
    localparam int RX_HDR_W = 18;             // Channel 0 receive header
    localparam int TX_HDR_W = 61;             // Channel 1 transmit header
    localparam int TAG_W    = 14;             // Request tag
    localparam int ADDR_W   = 32;             // Line address
    localparam int OP_W     = 4;              // Request opcode
    localparam int CSR_IDX_W = 14;            // CSR index in low bits of rx header

    // ----------------------------------------
    // Transmit header layout
    // ----------------------------------------
    // Bits above the opcode and between opcode and address stay zero
    localparam int HDR_TAG_LSB  = 0;
    localparam int HDR_ADDR_LSB = 14;
    localparam int HDR_OP_LSB   = 52;

    // ----------------------------------------
    // CSR indices decoded by the driver
    // ----------------------------------------
    localparam logic [CSR_IDX_W-1:0] CSR_TX_BASE     = 14'h0284;  // Ring base line address
    localparam logic [CSR_IDX_W-1:0] CSR_STATUS_BASE = 14'h0288;  // Status line address
    localparam logic [CSR_IDX_W-1:0] CSR_SREG_REQ    = 14'h028c;  // Status register request

    // Channel 1 write request opcodes
    typedef enum logic [OP_W-1:0]
    {
        WR_LINE   = 4'h2,                     // Normal line write to the ring
        WR_STATUS = 4'h1                      // Status line write
    } tx_req_e;

endpackage

/* verilog/drv_pkg.sv */
// --------------------------------------
// Driver client side
// Chunk and ring sizes, status bridge states
// --------------------------------------

package drv_pkg;

    // ----------------------------------------
    // Client chunk stream
    // ----------------------------------------
    localparam int UMF_W       = 64;                // One client chunk
    localparam int CHUNKS      = 4;                 // Chunks per line
    localparam int CHUNK_IDX_W = $clog2(CHUNKS);    // Chunk counter width

    // ----------------------------------------
    // Transmit ring
    // ----------------------------------------
    localparam int RING_LINES  = 16;                // Lines in the host ring
    localparam int RING_IDX_W  = $clog2(RING_LINES); // Wraps at ring size

    // Status bridge FSM
    typedef enum logic [1:0]
    {
        IDLE,                                       // No request open
        WAIT_CLIENT,                                // Request shown to client
        WAIT_WRITE                                  // Response waiting for channel 1
    } sreg_state_e;

endpackage

/* verilog/rx_unpacker.sv */
// --------------------------------------
// Receive unpacker
// Splits a message line into client chunks
// --------------------------------------
`timescale 1ns/1ns

module rx_unpacker
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic [cci_pkg::LINE_W-1:0]   line_in,
    input  logic                         line_valid,     // Registered message valid
    input  logic                         rx_fifo_enable, // Client pop
    output logic [drv_pkg::UMF_W-1:0]    rx_fifo_data,
    output logic                         rx_fifo_rdy
);

    import cci_pkg::*;
    import drv_pkg::*;

    logic [LINE_W-1:0]      line_q;     // Shifts down one chunk per pop
    logic [CHUNK_IDX_W-1:0] left;       // Chunks left after the current one
    logic                   busy;       // A chunk is on the output

    // ----------------------------------------
    // Chunk counter
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            left <= '0;
        end
        else if (line_valid)
        begin
            busy <= 1'b1;
            left <= CHUNK_IDX_W'(CHUNKS - 1);
        end
        else if (rx_fifo_enable)
        begin
            left <= left - 1'b1;
            if (left == '0)
                busy <= 1'b0;           // Last chunk taken
        end
    end

    // Line holder, lowest chunk first
    always_ff @(posedge clk)
    begin
        if (line_valid)
            line_q <= line_in;
        else if (rx_fifo_enable)
            line_q <= line_q >> UMF_W;
    end

    assign rx_fifo_data = line_q[UMF_W-1:0];
    assign rx_fifo_rdy  = busy;

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Host may send the next line only once the client has drained this one
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        line_valid |-> !busy)
        else $error("rx_unpacker message line overran pending chunks");

    // Client pops only while a chunk is shown
    a_no_empty_pop: assert property (@(posedge clk) disable iff (rst)
        rx_fifo_enable |-> busy)
        else $error("rx_unpacker pop while empty");

endmodule

/* verilog/tx_packer.sv */
// --------------------------------------
// Transmit packer
// Gathers client chunks into ring lines
// --------------------------------------
`timescale 1ns/1ns

module tx_packer
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          csr_valid,
    input  logic [cci_pkg::RX_HDR_W-1:0]  csr_hdr,
    input  logic [cci_pkg::LINE_W-1:0]    csr_data,
    input  logic [drv_pkg::UMF_W-1:0]     tx_fifo_data,
    input  logic                          tx_fifo_enable,  // Client push
    input  logic                          data_grant,      // One cycle pulse
    output logic                          tx_fifo_rdy,
    output logic [cci_pkg::LINE_W-1:0]    data_line,
    output logic [cci_pkg::ADDR_W-1:0]    data_addr,
    output logic                          data_req
);

    import cci_pkg::*;
    import drv_pkg::*;

    logic [ADDR_W-1:0]      ring_base;  // First line of the host ring
    logic [RING_IDX_W-1:0]  ring_idx;   // Wraps at ring size
    logic [CHUNK_IDX_W-1:0] chunk_idx;  // Next slot to fill
    logic                   full;       // Line waiting for a grant

    // ----------------------------------------
    // Control
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ring_base <= '0;
            ring_idx  <= '0;
            chunk_idx <= '0;
            full      <= 1'b0;
        end
        else
        begin
            if (csr_valid && (csr_hdr[CSR_IDX_W-1:0] == CSR_TX_BASE))
                ring_base <= csr_data[ADDR_W-1:0];
            if (tx_fifo_enable)
            begin
                chunk_idx <= chunk_idx + 1'b1;
                if (chunk_idx == CHUNK_IDX_W'(CHUNKS - 1))
                    full <= 1'b1;       // Fourth chunk closes the line
            end
            if (data_grant)
            begin
                full     <= 1'b0;
                ring_idx <= ring_idx + 1'b1;
            end
        end
    end

    // Fill slots lowest first
    always_ff @(posedge clk)
    begin
        if (tx_fifo_enable)
            data_line[chunk_idx * UMF_W +: UMF_W] <= tx_fifo_data;
    end

    assign tx_fifo_rdy = !full;
    assign data_req    = full;
    assign data_addr   = ring_base + ADDR_W'(ring_idx);

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_push_rdy: assert property (@(posedge clk) disable iff (rst)
        tx_fifo_enable |-> tx_fifo_rdy)
        else $error("tx_packer push while tx_fifo_rdy low");

endmodule

/* verilog/sreg_bridge.sv */
// --------------------------------------
// Status register bridge
// Passes host status requests to the client and writes the answer back
// --------------------------------------
`timescale 1ns/1ns

module sreg_bridge
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          csr_valid,
    input  logic [cci_pkg::RX_HDR_W-1:0]  csr_hdr,
    input  logic [cci_pkg::LINE_W-1:0]    csr_data,
    input  logic [63:0]                   sreg_rsp,
    input  logic                          sreg_rsp_enable,  // One cycle pulse
    input  logic                          status_grant,
    output logic [31:0]                   sreg_req_addr,
    output logic                          sreg_req_rdy,
    output logic [cci_pkg::LINE_W-1:0]    status_line,
    output logic [cci_pkg::ADDR_W-1:0]    status_addr,
    output logic                          status_req
);

    import cci_pkg::*;
    import drv_pkg::*;

    sreg_state_e       state;
    logic [ADDR_W-1:0] status_base;
    logic [63:0]       rsp_q;
    logic              req_csr;            // Status request write seen

    assign req_csr = csr_valid && (csr_hdr[CSR_IDX_W-1:0] == CSR_SREG_REQ);

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= IDLE;
            status_base <= '0;
        end
        else
        begin
            if (csr_valid && (csr_hdr[CSR_IDX_W-1:0] == CSR_STATUS_BASE))
                status_base <= csr_data[ADDR_W-1:0];
            case (state)
                IDLE:        if (req_csr) state <= WAIT_CLIENT;   // Later requests dropped
                WAIT_CLIENT: if (sreg_rsp_enable) state <= WAIT_WRITE;
                WAIT_WRITE:  if (status_grant) state <= IDLE;
                default:     state <= IDLE;
            endcase
        end
    end

    // Request address and response capture
    always_ff @(posedge clk)
    begin
        if ((state == IDLE) && req_csr)
            sreg_req_addr <= csr_data[31:0];
        if ((state == WAIT_CLIENT) && sreg_rsp_enable)
            rsp_q <= sreg_rsp;
    end

    assign sreg_req_rdy = (state == WAIT_CLIENT);
    assign status_req   = (state == WAIT_WRITE);
    assign status_addr  = status_base;
    assign status_line  = {{(LINE_W - 64){1'b0}}, rsp_q};    // Zero extended answer

    // Client answers once, only to an open request
    a_rsp_open: assert property (@(posedge clk) disable iff (rst)
        sreg_rsp_enable |-> (state == WAIT_CLIENT))
        else $error("sreg_bridge response without open request");

endmodule

/* verilog/tx_arbiter.sv */
// --------------------------------------
// Channel 1 write arbiter
// Status first, tags each write, holds off on almost full
// --------------------------------------
`timescale 1ns/1ns

module tx_arbiter
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          alm_full,      // Registered link level
    input  logic                          data_req,
    input  logic [cci_pkg::LINE_W-1:0]    data_line,
    input  logic [cci_pkg::ADDR_W-1:0]    data_addr,
    input  logic                          status_req,
    input  logic [cci_pkg::LINE_W-1:0]    status_line,
    input  logic [cci_pkg::ADDR_W-1:0]    status_addr,
    output logic                          data_grant,
    output logic                          status_grant,
    output logic [cci_pkg::TX_HDR_W-1:0]  c1_hdr,
    output logic [cci_pkg::LINE_W-1:0]    c1_data,
    output logic                          c1_wr_valid
);

    import cci_pkg::*;

    logic [TAG_W-1:0]    tag;           // Rises by one per write
    tx_req_e             op;
    logic [TX_HDR_W-1:0] hdr_next;

    // Status wins and nothing goes while the link is almost full
    assign status_grant = status_req && !alm_full;
    assign data_grant   = data_req && !status_req && !alm_full;

    // ----------------------------------------
    // Header build
    // ----------------------------------------
    always_comb
    begin
        op       = status_grant ? WR_STATUS : WR_LINE;
        hdr_next = '0;
        hdr_next[HDR_OP_LSB +: OP_W]     = op;
        hdr_next[HDR_ADDR_LSB +: ADDR_W] = status_grant ? status_addr : data_addr;
        hdr_next[HDR_TAG_LSB +: TAG_W]   = tag;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            c1_wr_valid <= 1'b0;
            tag         <= '0;
        end
        else
        begin
            c1_wr_valid <= status_grant || data_grant;
            if (status_grant || data_grant)
                tag <= tag + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (status_grant || data_grant)
        begin
            c1_hdr  <= hdr_next;
            c1_data <= status_grant ? status_line : data_line;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        !(status_grant && data_grant))
        else $error("tx_arbiter granted both sources");

endmodule

/* verilog/qa_driver.sv */
// --------------------------------------
// Host channel driver top level
// Registers the link and joins stream, status and arbiter blocks
// --------------------------------------
`timescale 1ns/1ns

module qa_driver
(
    input  logic                           clk,
    input  logic                           rst,               // Soft reset
    // Link channel 0 receive
    input  logic [cci_pkg::RX_HDR_W-1:0]   c0_rx_hdr,
    input  logic [cci_pkg::LINE_W-1:0]     c0_rx_data,
    input  logic                           c0_rx_csr_valid,
    input  logic                           c0_rx_umsg_valid,
    input  logic                           c1_tx_alm_full,
    input  logic                           init_done,         // Link ready level
    // Client receive FIFO
    output logic [drv_pkg::UMF_W-1:0]      rx_fifo_data,
    output logic                           rx_fifo_rdy,
    input  logic                           rx_fifo_enable,
    // Client transmit FIFO
    input  logic [drv_pkg::UMF_W-1:0]      tx_fifo_data,
    output logic                           tx_fifo_rdy,
    input  logic                           tx_fifo_enable,
    // Client status port
    output logic [31:0]                    sreg_req_addr,
    output logic                           sreg_req_rdy,
    input  logic [63:0]                    sreg_rsp,
    input  logic                           sreg_rsp_enable,
    // Link channel 1 write
    output logic [cci_pkg::TX_HDR_W-1:0]   c1_tx_hdr,
    output logic [cci_pkg::LINE_W-1:0]     c1_tx_data,
    output logic                           c1_tx_wr_valid
);

    import cci_pkg::*;

    logic                drv_rst;       // Soft reset or link not ready
    logic [RX_HDR_W-1:0] rx_hdr_q;
    logic [LINE_W-1:0]   rx_data_q;
    logic                csr_valid_q;
    logic                umsg_valid_q;
    logic                alm_full_q;

    // Source to arbiter nets
    logic [LINE_W-1:0]   data_line;
    logic [ADDR_W-1:0]   data_addr;
    logic                data_req;
    logic                data_grant;
    logic [LINE_W-1:0]   status_line;
    logic [ADDR_W-1:0]   status_addr;
    logic                status_req;
    logic                status_grant;

    logic [TX_HDR_W-1:0] c1_hdr;        // Arbiter output before port register
    logic [LINE_W-1:0]   c1_data;
    logic                c1_wr_valid;

    assign drv_rst = rst || !init_done;

    // ----------------------------------------
    // Link port registers
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (drv_rst)
        begin
            csr_valid_q    <= 1'b0;
            umsg_valid_q   <= 1'b0;
            alm_full_q     <= 1'b1;      // Stall until the link is sampled
            c1_tx_wr_valid <= 1'b0;
        end
        else
        begin
            csr_valid_q    <= c0_rx_csr_valid;
            umsg_valid_q   <= c0_rx_umsg_valid;
            alm_full_q     <= c1_tx_alm_full;
            c1_tx_wr_valid <= c1_wr_valid;
        end
    end

    // Payload side of the port registers
    always_ff @(posedge clk)
    begin
        rx_hdr_q   <= c0_rx_hdr;
        rx_data_q  <= c0_rx_data;
        c1_tx_hdr  <= c1_hdr;
        c1_tx_data <= c1_data;
    end

    // ----------------------------------------
    // Channel blocks
    // ----------------------------------------
    rx_unpacker u_rx_unpacker
    (
        .clk, .rst(drv_rst),
        .line_in(rx_data_q), .line_valid(umsg_valid_q),
        .rx_fifo_enable, .rx_fifo_data, .rx_fifo_rdy
    );

    tx_packer u_tx_packer
    (
        .clk, .rst(drv_rst),
        .csr_valid(csr_valid_q), .csr_hdr(rx_hdr_q), .csr_data(rx_data_q),
        .tx_fifo_data, .tx_fifo_enable, .data_grant,
        .tx_fifo_rdy, .data_line, .data_addr, .data_req
    );

    sreg_bridge u_sreg_bridge
    (
        .clk, .rst(drv_rst),
        .csr_valid(csr_valid_q), .csr_hdr(rx_hdr_q), .csr_data(rx_data_q),
        .sreg_rsp, .sreg_rsp_enable, .status_grant,
        .sreg_req_addr, .sreg_req_rdy, .status_line, .status_addr, .status_req
    );

    tx_arbiter u_tx_arbiter
    (
        .clk, .rst(drv_rst), .alm_full(alm_full_q),
        .data_req, .data_line, .data_addr,
        .status_req, .status_line, .status_addr,
        .data_grant, .status_grant, .c1_hdr, .c1_data, .c1_wr_valid
    );

endmodule

/* verif/tb_qa_driver.sv */
// ----------------------------------------
// Testbench for the host channel driver
// Host link and client models with a scoreboard checked by assertions
// ----------------------------------------
`timescale 1ns/1ns

module tb_qa_driver;

    import cci_pkg::*;
    import drv_pkg::*;

    localparam int TIMEOUT = 200;              // Cycles allowed per wait

    logic                clk;
    logic                rst;
    logic [RX_HDR_W-1:0] c0_rx_hdr;
    logic [LINE_W-1:0]   c0_rx_data;
    logic                c0_rx_csr_valid;
    logic                c0_rx_umsg_valid;
    logic                c1_tx_alm_full;
    logic                init_done;
    logic [UMF_W-1:0]    rx_fifo_data;
    logic                rx_fifo_rdy;
    logic                rx_fifo_enable;
    logic [UMF_W-1:0]    tx_fifo_data;
    logic                tx_fifo_rdy;
    logic                tx_fifo_enable;
    logic [31:0]         sreg_req_addr;
    logic                sreg_req_rdy;
    logic [63:0]         sreg_rsp;
    logic                sreg_rsp_enable;
    logic [TX_HDR_W-1:0] c1_tx_hdr;
    logic [LINE_W-1:0]   c1_tx_data;
    logic                c1_tx_wr_valid;

    // ----------------------------------------
    // Scoreboard
    // ----------------------------------------
    logic [TX_HDR_W-1:0] exp_hdr [0:31];       // Channel 1 writes in issue order
    logic [LINE_W-1:0]   exp_data [0:31];
    logic [4:0]          wr_count;             // Writes expected so far
    logic [4:0]          wr_idx;               // Writes seen on the port
    logic [UMF_W-1:0]    exp_chunk [0:15];     // Receive chunks in pop order
    logic [3:0]          rx_count;
    logic [3:0]          rx_idx;
    logic [31:0]         exp_sreg_addr;
    logic                expect_quiet;         // Almost full held long enough
    logic [TAG_W-1:0]    next_tag;
    logic [31:0]         ring_base;
    logic [31:0]         status_base;
    int                  ring_lines;           // Ring lines expected so far
    int                  mismatches;
    int                  failures;
    integer              seed;
    string               test_name;

    qa_driver dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                 // 8 ns period
    end

    // Seen counters move after the checks of the same edge
    always @(posedge clk)
    begin
        if (rst)
        begin
            wr_idx <= '0;
            rx_idx <= '0;
        end
        else
        begin
            if (c1_tx_wr_valid)
                wr_idx <= wr_idx + 5'd1;
            if (rx_fifo_enable)
                rx_idx <= rx_idx + 4'd1;
        end
    end

    // ----------------------------------------
    // Checking assertions
    // ----------------------------------------
    a_wr_hdr: assert property (@(posedge clk) disable iff (rst)
        c1_tx_wr_valid |-> (c1_tx_hdr == exp_hdr[wr_idx]))
        else
        begin
            mismatches++;
            $display("MISMATCH %s header: expected %h actual %h",
                test_name, $sampled(exp_hdr[wr_idx]), $sampled(c1_tx_hdr));
        end

    a_wr_data: assert property (@(posedge clk) disable iff (rst)
        c1_tx_wr_valid |-> (c1_tx_data == exp_data[wr_idx]))
        else
        begin
            mismatches++;
            $display("MISMATCH %s data: expected %h actual %h",
                test_name, $sampled(exp_data[wr_idx]), $sampled(c1_tx_data));
        end

    a_rx_chunk: assert property (@(posedge clk) disable iff (rst)
        rx_fifo_enable |-> (rx_fifo_data == exp_chunk[rx_idx]))
        else
        begin
            mismatches++;
            $display("MISMATCH %s chunk: expected %h actual %h",
                test_name, $sampled(exp_chunk[rx_idx]), $sampled(rx_fifo_data));
        end

    a_sreg_addr: assert property (@(posedge clk) disable iff (rst)
        sreg_req_rdy |-> (sreg_req_addr == exp_sreg_addr))
        else
        begin
            mismatches++;
            $display("MISMATCH %s sreg_req_addr: expected %h actual %h",
                test_name, $sampled(exp_sreg_addr), $sampled(sreg_req_addr));
        end

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        expect_quiet |-> !c1_tx_wr_valid)
        else
        begin
            failures++;
            $display("A channel 1 write went out while almost full was held high");
        end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic finish_run;
        $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic give_up(input string what);
        failures++;
        $display("Timeout while waiting for %s", what);
        finish_run();
    endtask

    task automatic check_value(input string name, input int exp, input int act);
        assert (act == exp)
        else
        begin
            mismatches++;
            $display("MISMATCH %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic random_line(output logic [LINE_W-1:0] value);
        int i;
        value = '0;
        for (i = 0; i < LINE_W / 32; i++)
            value = {value[LINE_W-33:0], 32'($random(seed))};
    endtask

    // Chunk idx of a line with chunk 0 in the lowest bits
    function automatic logic [UMF_W-1:0] chunk_of(input logic [LINE_W-1:0] value,
                                                  input int idx);
        return UMF_W'(value >> (idx * UMF_W));
    endfunction

    task automatic csr_write(input logic [CSR_IDX_W-1:0] idx, input logic [31:0] value);
        c0_rx_hdr       = RX_HDR_W'(idx);      // Index in the low header bits
        c0_rx_data      = LINE_W'(value);
        c0_rx_csr_valid = 1'b1;
        @(negedge clk);
        c0_rx_csr_valid = 1'b0;
    endtask

    // Header is spare, opcode, spare, line address, tag from the top down
    task automatic expect_write(input tx_req_e op, input logic [31:0] addr,
                                input logic [LINE_W-1:0] data);
        exp_hdr[wr_count]  = {5'b0, op, 6'b0, addr, next_tag};
        exp_data[wr_count] = data;
        wr_count = wr_count + 5'd1;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic expect_line(input logic [LINE_W-1:0] data);
        expect_write(WR_LINE, ring_base + 32'(ring_lines % RING_LINES), data);
        ring_lines++;
    endtask

    // Client side of the transmit FIFO pushing one random line
    task automatic push_line(output logic [LINE_W-1:0] value);
        int i;
        int t;
        random_line(value);
        for (i = 0; i < CHUNKS; i++)
        begin
            t = 0;
            while (!tx_fifo_rdy && t < TIMEOUT)
            begin
                @(negedge clk);
                t++;
            end
            if (!tx_fifo_rdy)
                give_up("tx_fifo_rdy before a push");
            else
            begin
                tx_fifo_data   = chunk_of(value, i);
                tx_fifo_enable = 1'b1;
                @(negedge clk);
                tx_fifo_enable = 1'b0;
            end
        end
    endtask

    // Client status model that answers after a random delay
    task automatic answer_status(output logic [63:0] rsp);
        int t;
        int delay;
        t = 0;
        rsp = '0;
        while (!sreg_req_rdy && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (!sreg_req_rdy)
            give_up("sreg_req_rdy after a status request");
        else
        begin
            delay = 1 + ($random(seed) & 7);
            repeat (delay) @(negedge clk);
            rsp             = {$random(seed), $random(seed)};
            sreg_rsp        = rsp;
            sreg_rsp_enable = 1'b1;
            @(negedge clk);
            sreg_rsp_enable = 1'b0;
            check_value({test_name, " sreg_req_rdy fall"}, 0, int'(sreg_req_rdy));
        end
    endtask

    task automatic wait_writes;
        int t;
        t = 0;
        while (wr_idx != wr_count && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (wr_idx != wr_count)
            give_up("the expected channel 1 writes");
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial
    begin
        logic [LINE_W-1:0] line;
        logic [63:0]       rsp;
        int                cycles;
        int                i;
        int                n;

        seed             = 32'h041c_7282;
        wr_count         = '0;
        rx_count         = '0;
        next_tag         = '0;
        ring_lines       = 0;
        mismatches       = 0;
        failures         = 0;
        expect_quiet     = 1'b0;
        exp_sreg_addr    = '0;
        ring_base        = '0;
        status_base      = '0;
        test_name        = "reset";
        rst              = 1'b1;
        init_done        = 1'b1;
        c0_rx_hdr        = '0;
        c0_rx_data       = '0;
        c0_rx_csr_valid  = 1'b0;
        c0_rx_umsg_valid = 1'b0;
        c1_tx_alm_full   = 1'b0;
        rx_fifo_enable   = 1'b0;
        tx_fifo_data     = '0;
        tx_fifo_enable   = 1'b0;
        sreg_rsp         = '0;
        sreg_rsp_enable  = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Idle levels out of reset
        check_value("reset rx_fifo_rdy", 0, int'(rx_fifo_rdy));
        check_value("reset sreg_req_rdy", 0, int'(sreg_req_rdy));
        check_value("reset c1_tx_wr_valid", 0, int'(c1_tx_wr_valid));
        check_value("reset tx_fifo_rdy", 1, int'(tx_fifo_rdy));

        // Receive lines with chunks lowest first
        test_name = "receive";
        for (n = 0; n < 3; n++)
        begin
            random_line(line);
            for (i = 0; i < CHUNKS; i++)
            begin
                exp_chunk[rx_count] = chunk_of(line, i);
                rx_count = rx_count + 4'd1;
            end
            c0_rx_data       = line;
            c0_rx_umsg_valid = 1'b1;
            cycles           = 0;
            while (!rx_fifo_rdy && cycles < TIMEOUT)
            begin
                @(negedge clk);
                c0_rx_umsg_valid = 1'b0;       // One cycle message pulse
                cycles++;
            end
            if (!rx_fifo_rdy)
                give_up("rx_fifo_rdy after a message line");
            else
            begin
                check_value("receive latency", 2, cycles);
                for (i = 0; i < CHUNKS; i++)
                begin
                    rx_fifo_enable = 1'b1;
                    @(negedge clk);
                end
                rx_fifo_enable = 1'b0;
                check_value("receive drained", 0, int'(rx_fifo_rdy));
            end
        end

        // Ring writes wrap after 16 lines
        test_name = "ring";
        ring_base = $random(seed);
        csr_write(CSR_TX_BASE, ring_base);
        for (n = 0; n < 18; n++)
        begin
            push_line(line);
            expect_line(line);
        end
        wait_writes();

        // Status round trip
        test_name     = "status";
        status_base   = $random(seed);
        exp_sreg_addr = $random(seed);
        csr_write(CSR_STATUS_BASE, status_base);
        csr_write(CSR_SREG_REQ, exp_sreg_addr);
        answer_status(rsp);
        expect_write(WR_STATUS, status_base, LINE_W'(rsp));
        wait_writes();

        // Status goes first once both sources wait out almost full
        test_name      = "priority";
        c1_tx_alm_full = 1'b1;
        @(negedge clk);
        expect_quiet   = 1'b1;
        push_line(line);
        exp_sreg_addr  = $random(seed);
        csr_write(CSR_SREG_REQ, exp_sreg_addr);
        answer_status(rsp);
        repeat (10) @(negedge clk);
        check_value("priority line held", 0, int'(tx_fifo_rdy));
        expect_write(WR_STATUS, status_base, LINE_W'(rsp));
        expect_line(line);
        c1_tx_alm_full = 1'b0;
        expect_quiet   = 1'b0;
        wait_writes();

        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

/* project.f */
verilog/cci_pkg.sv
verilog/drv_pkg.sv
verilog/rx_unpacker.sv
verilog/tx_packer.sv
verilog/sreg_bridge.sv
verilog/tx_arbiter.sv
verilog/qa_driver.sv
verif/tb_qa_driver.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the qa_driver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_qa_driver -f project.f

sim_out=$(./obj_dir/Vtb_qa_driver)
echo "$sim_out"

# Result comes from the testbench summary
if echo "$sim_out" | grep -q "PASS: all tests"; then
    exit 0
fi
exit 1
